//--- verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// physical address width
`define DC_ADDR_W 32

// cpu word and memory beat width
`define DC_DATA_W 64

// associativity
`define DC_WAYS 4

// sets, indexed by addr[9:6]
`define DC_SETS 16

// 64-bit words in one 64-byte line
`define DC_LINE_BEATS 8

// tag taken from addr[31:10]
`define DC_TAG_W 22

// everything from here up is uncached device space
`define DC_DEVICE_BASE 32'h9000_0000

`endif

//--- verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

	// one bit per way, one-hot or all zero
	typedef logic [`DC_WAYS-1:0] way_mask_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		REFILL,
		DEV_READ,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		RESPOND
	} dc_state_e;

endpackage

`default_nettype wire

//--- verilog/dcache_tags.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_tags
	import dcache_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst,
	input  wire [`DC_ADDR_W-1:0]  addr,
	input  wire                   fill,
	output way_mask_t             hit,
	output way_mask_t             victim
);

	// byte offset inside a line, then set index above it
	localparam int OFF_W = $clog2(`DC_LINE_BEATS) + $clog2(`DC_DATA_W / 8);
	localparam int IDX_W = $clog2(`DC_SETS);

	// tag storage, one entry per way and set
	logic [`DC_TAG_W-1:0] tag_mem [`DC_WAYS][`DC_SETS];

	// valid bits, packed so reset can clear them in one go
	logic [`DC_WAYS-1:0][`DC_SETS-1:0] vld;

	// one-hot replacement pointer
	way_mask_t victim_q;

	logic [IDX_W-1:0]     index;
	logic [`DC_TAG_W-1:0] tag;

	assign index = addr[OFF_W +: IDX_W];
	assign tag   = addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			hit[w] = vld[w][index] && (tag_mem[w][index] == tag);
		end
	end

	assign victim = victim_q;

	// valid bits and victim pointer
	always_ff @(posedge clk) begin
		if (rst) begin
			vld      <= '0;
			// way 0 is the first to be filled
			victim_q <= way_mask_t'(1);
		end else if (fill) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (victim_q[w]) begin
					vld[w][index] <= 1'b1;
				end
			end
			// rotate left by one way per completed refill
			victim_q <= {victim_q[`DC_WAYS-2:0], victim_q[`DC_WAYS-1]};
		end
	end

	// tag write into the victim way of the indexed set
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (victim_q[w]) begin
					tag_mem[w][index] <= tag;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache_data.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_data
	import dcache_pkg::*;
(
	input  wire                                clk,
	input  wire [`DC_ADDR_W-1:0]               addr,
	input  way_mask_t                          hit,
	input  wire                                refill_we,
	input  way_mask_t                          refill_way,
	input  wire [$clog2(`DC_LINE_BEATS)-1:0]   refill_beat,
	input  wire [`DC_DATA_W-1:0]               refill_data,
	input  wire                                store_we,
	input  wire [`DC_DATA_W-1:0]               store_data,
	input  wire [`DC_DATA_W/8-1:0]             store_strb,
	output logic [`DC_DATA_W-1:0]              line_word
);

	localparam int STRB_W = `DC_DATA_W / 8;
	localparam int BYTE_W = $clog2(STRB_W);
	localparam int BEAT_W = $clog2(`DC_LINE_BEATS);
	localparam int OFF_W  = BEAT_W + BYTE_W;
	localparam int IDX_W  = $clog2(`DC_SETS);
	localparam int WORDS  = `DC_SETS * `DC_LINE_BEATS;

	// line storage, set index on top of the word number
	logic [`DC_DATA_W-1:0] mem [`DC_WAYS][WORDS];

	logic [IDX_W-1:0]        index;
	logic [IDX_W+BEAT_W-1:0] word_addr;
	logic [IDX_W+BEAT_W-1:0] fill_addr;

	assign index     = addr[OFF_W +: IDX_W];
	// word the cpu is pointing at
	assign word_addr = {index, addr[BYTE_W +: BEAT_W]};
	// refill walks the line beat by beat
	assign fill_addr = {index, refill_beat};

	// refill takes priority, store only touches the hit way
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (refill_we && refill_way[w]) begin
				mem[w][fill_addr] <= refill_data;
			end else if (store_we && hit[w]) begin
				// merge only the strobed bytes
				for (int b = 0; b < STRB_W; b++) begin
					if (store_strb[b]) begin
						mem[w][word_addr][8*b +: 8] <= store_data[8*b +: 8];
					end
				end
			end
		end
	end

	// registered read, ready one cycle after the lookup
	always_ff @(posedge clk) begin
		line_word <= '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (hit[w]) begin
				line_word <= mem[w][word_addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input  wire                                clk,
	input  wire                                rst,
	// cpu side
	input  wire                                valid,
	input  wire [`DC_ADDR_W-1:0]               addr,
	input  wire                                wren,
	input  wire [`DC_DATA_W-1:0]               din,
	input  wire [`DC_DATA_W/8-1:0]             mask,
	output logic                               ready,
	output logic [`DC_DATA_W-1:0]              dout,
	// tag and data arrays
	input  way_mask_t                          hit,
	input  way_mask_t                          victim,
	input  wire [`DC_DATA_W-1:0]               line_word,
	output logic                               fill,
	output logic                               refill_we,
	output way_mask_t                          refill_way,
	output logic [$clog2(`DC_LINE_BEATS)-1:0]  refill_beat,
	output logic [`DC_DATA_W-1:0]              refill_data,
	output logic                               store_we,
	// read address and data channels
	output logic [`DC_ADDR_W-1:0]              araddr,
	output logic [7:0]                         arlen,
	output logic                               arvalid,
	input  wire                                arready,
	input  wire [`DC_DATA_W-1:0]               rdata,
	input  wire                                rlast,
	input  wire                                rvalid,
	// write address, data and response channels
	output logic [`DC_ADDR_W-1:0]              awaddr,
	output logic                               awvalid,
	input  wire                                awready,
	output logic [`DC_DATA_W-1:0]              wdata,
	output logic [`DC_DATA_W/8-1:0]            wstrb,
	output logic                               wvalid,
	input  wire                                wready,
	input  wire                                bvalid
);

	localparam int BEAT_W = $clog2(`DC_LINE_BEATS);
	localparam int OFF_W  = BEAT_W + $clog2(`DC_DATA_W / 8);

	dc_state_e state;
	dc_state_e state_nxt;

	logic                  cacheable;
	logic                  rd_start;
	logic                  ar_hs;
	logic                  r_beat;
	logic [BEAT_W-1:0]     beat_cnt;
	way_mask_t             fill_way;
	logic [`DC_DATA_W-1:0] dev_word;

	// below the device base everything is cached
	assign cacheable = addr < `DC_DEVICE_BASE;

	// read that has to go out to memory: a miss or any device read
	assign rd_start = (state == IDLE) && valid && !wren && (!cacheable || (hit == '0));

	assign ar_hs = arvalid && arready;
	// R beats only count once the address has been taken
	assign r_beat = rvalid && !arvalid;

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (valid) begin
					if (wren) begin
						state_nxt = WR_ADDR;
					end else if (!cacheable) begin
						state_nxt = DEV_READ;
					end else if (hit != '0) begin
						state_nxt = RESPOND;
					end else begin
						state_nxt = REFILL;
					end
				end
			end
			REFILL: begin
				// back to IDLE so the lookup sees the new line
				if (r_beat && rlast) begin
					state_nxt = IDLE;
				end
			end
			DEV_READ: begin
				if (r_beat) begin
					state_nxt = RESPOND;
				end
			end
			WR_ADDR: begin
				if (awready) begin
					state_nxt = WR_DATA;
				end
			end
			WR_DATA: begin
				if (wready) begin
					state_nxt = WR_RESP;
				end
			end
			WR_RESP: begin
				if (bvalid) begin
					state_nxt = RESPOND;
				end
			end
			RESPOND: begin
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// arvalid rises the cycle after the request, held until taken
	always_ff @(posedge clk) begin
		if (rst) begin
			arvalid <= 1'b0;
		end else if (rd_start) begin
			arvalid <= 1'b1;
		end else if (ar_hs) begin
			arvalid <= 1'b0;
		end
	end

	// beat counter restarts with each burst
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (ar_hs) begin
			beat_cnt <= '0;
		end else if (refill_we) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// victim is frozen at the AR handshake, counter only moves on fill
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			fill_way <= victim;
		end
	end

	// single device beat kept for the response cycle
	always_ff @(posedge clk) begin
		if ((state == DEV_READ) && r_beat) begin
			dev_word <= rdata;
		end
	end

	// cpu response, addr is still held so it picks the source
	assign ready = (state == RESPOND);
	assign dout  = cacheable ? line_word : dev_word;

	// refill path into the arrays
	assign refill_we   = (state == REFILL) && r_beat;
	assign fill        = refill_we && rlast;
	assign refill_way  = fill_way;
	assign refill_beat = beat_cnt;
	assign refill_data = rdata;

	// write hit updates the line in the sampling cycle
	assign store_we = (state == IDLE) && valid && wren && (hit != '0);

	// line-aligned burst for the cache, one beat for devices
	assign araddr = cacheable ? {addr[`DC_ADDR_W-1:OFF_W], {OFF_W{1'b0}}} : addr;
	assign arlen  = cacheable ? 8'(`DC_LINE_BEATS - 1) : 8'd0;

	// write-through, single beat straight from the cpu port
	assign awaddr  = addr;
	assign awvalid = (state == WR_ADDR);
	assign wdata   = din;
	assign wstrb   = mask;
	assign wvalid  = (state == WR_DATA);

endmodule

`default_nettype wire

//--- verilog/dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache
	import dcache_pkg::*;
(
	input  wire                      clk,
	input  wire                      rst,
	// cpu request port
	input  wire                      valid,
	input  wire [`DC_ADDR_W-1:0]     addr,
	input  wire                      wren,
	input  wire [`DC_DATA_W-1:0]     din,
	input  wire [`DC_DATA_W/8-1:0]   mask,
	output wire                      ready,
	output wire [`DC_DATA_W-1:0]     dout,
	// memory side
	output wire [`DC_ADDR_W-1:0]     araddr,
	output wire [7:0]                arlen,
	output wire                      arvalid,
	input  wire                      arready,
	input  wire [`DC_DATA_W-1:0]     rdata,
	input  wire                      rlast,
	input  wire                      rvalid,
	output wire [`DC_ADDR_W-1:0]     awaddr,
	output wire                      awvalid,
	input  wire                      awready,
	output wire [`DC_DATA_W-1:0]     wdata,
	output wire [`DC_DATA_W/8-1:0]   wstrb,
	output wire                      wvalid,
	input  wire                      wready,
	input  wire                      bvalid
);

	way_mask_t                          hit;
	way_mask_t                          victim;
	way_mask_t                          refill_way;
	wire                                fill;
	wire                                refill_we;
	wire [$clog2(`DC_LINE_BEATS)-1:0]   refill_beat;
	wire [`DC_DATA_W-1:0]               refill_data;
	wire                                store_we;
	wire [`DC_DATA_W-1:0]               line_word;

	// tags and data look up the same address side by side
	dcache_tags i_tags (
		.clk    (clk),
		.rst    (rst),
		.addr   (addr),
		.fill   (fill),
		.hit    (hit),
		.victim (victim)
	);

	// store data and strobes come straight off the cpu port
	dcache_data i_data (
		.clk         (clk),
		.addr        (addr),
		.hit         (hit),
		.refill_we   (refill_we),
		.refill_way  (refill_way),
		.refill_beat (refill_beat),
		.refill_data (refill_data),
		.store_we    (store_we),
		.store_data  (din),
		.store_strb  (mask),
		.line_word   (line_word)
	);

	dcache_ctrl i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.valid       (valid),
		.addr        (addr),
		.wren        (wren),
		.din         (din),
		.mask        (mask),
		.ready       (ready),
		.dout        (dout),
		.hit         (hit),
		.victim      (victim),
		.line_word   (line_word),
		.fill        (fill),
		.refill_we   (refill_we),
		.refill_way  (refill_way),
		.refill_beat (refill_beat),
		.refill_data (refill_data),
		.store_we    (store_we),
		.araddr      (araddr),
		.arlen       (arlen),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bvalid      (bvalid)
	);

endmodule

`default_nettype wire

//--- tb/dcache_sva.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_sva (
	input wire       clk,
	input wire       rst,
	input wire       ready,
	input wire       arvalid,
	input wire       arready,
	input wire       awvalid,
	input wire       awready,
	input wire       wvalid,
	input wire       wready
);

	// failure tally, read back by the testbench at the end
	int unsigned fails;

	// response is a single-cycle pulse
	a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else begin
			fails++;
			$error("ready high for two cycles in a row");
		end

	// request valids hold until taken
	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid)
		else begin
			fails++;
			$error("arvalid dropped before handshake");
		end

	a_aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid)
		else begin
			fails++;
			$error("awvalid dropped before handshake");
		end

	a_w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid)
		else begin
			fails++;
			$error("wvalid dropped before handshake");
		end

	// one outstanding memory request at a time
	a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid))
		else begin
			fails++;
			$error("arvalid and awvalid both high");
		end

	// quiet outputs right after reset
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !ready && !arvalid && !awvalid && !wvalid)
		else begin
			fails++;
			$error("outputs not low after reset");
		end

endmodule

`default_nettype wire

//--- tb/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;

	localparam int WAIT_LIMIT = 200;

	logic                      clk;
	logic                      rst;
	logic                      valid;
	logic [`DC_ADDR_W-1:0]     addr;
	logic                      wren;
	logic [`DC_DATA_W-1:0]     din;
	logic [`DC_DATA_W/8-1:0]   mask;
	wire                       ready;
	wire  [`DC_DATA_W-1:0]     dout;
	wire  [`DC_ADDR_W-1:0]     araddr;
	wire  [7:0]                arlen;
	wire                       arvalid;
	logic                      arready;
	logic [`DC_DATA_W-1:0]     rdata;
	logic                      rlast;
	logic                      rvalid;
	wire  [`DC_ADDR_W-1:0]     awaddr;
	wire                       awvalid;
	logic                      awready;
	wire  [`DC_DATA_W-1:0]     wdata;
	wire  [`DC_DATA_W/8-1:0]   wstrb;
	wire                       wvalid;
	logic                      wready;
	logic                      bvalid;

	integer value_errs = 0;
	integer timeouts = 0;
	// AR handshakes seen by the memory model, plus the last request
	integer ar_count = 0;
	logic [`DC_ADDR_W-1:0] last_araddr;
	logic [7:0]            last_arlen;
	// separate streams for stimulus and back-pressure
	integer stim_seed = 53360;
	integer model_seed = 53360;

	// model memory and the expected view of it, keyed by word address
	logic [`DC_DATA_W-1:0] mem_words [logic [`DC_ADDR_W-1:0]];
	logic [`DC_DATA_W-1:0] shadow [logic [`DC_ADDR_W-1:0]];

	dcache i_dut (
		.clk     (clk),
		.rst     (rst),
		.valid   (valid),
		.addr    (addr),
		.wren    (wren),
		.din     (din),
		.mask    (mask),
		.ready   (ready),
		.dout    (dout),
		.araddr  (araddr),
		.arlen   (arlen),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rlast   (rlast),
		.rvalid  (rvalid),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid)
	);

	bind dcache_ctrl dcache_sva i_sva (
		.clk        (clk),
		.rst        (rst),
		.ready      (ready),
		.arvalid    (arvalid),
		.arready    (arready),
		.awvalid    (awvalid),
		.awready    (awready),
		.wvalid     (wvalid),
		.wready     (wready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// untouched memory, every address bit shows up in the word
	function automatic logic [63:0] fill_word(input logic [31:0] wa);
		fill_word = {wa ^ 32'h5ac3_96e1, ~wa + 32'h1357_9bdf};
	endfunction

	function automatic logic [63:0] mem_word(input logic [31:0] a);
		logic [31:0] wa;
		wa = {a[31:3], 3'b000};
		mem_word = mem_words.exists(wa) ? mem_words[wa] : fill_word(wa);
	endfunction

	function automatic logic [63:0] shadow_word(input logic [31:0] a);
		logic [31:0] wa;
		wa = {a[31:3], 3'b000};
		shadow_word = shadow.exists(wa) ? shadow[wa] : fill_word(wa);
	endfunction

	// byte-strobed write merge
	function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] nw,
			input logic [7:0] m);
		logic [63:0] r;
		r = old;
		for (int b = 0; b < 8; b++) begin
			if (m[b]) begin
				r[8*b +: 8] = nw[8*b +: 8];
			end
		end
		merge_bytes = r;
	endfunction

	// back-pressure of 0 to 2 cycles
	function automatic integer pick_delay();
		pick_delay = $unsigned($random(model_seed)) % 3;
	endfunction

	task automatic final_report;
		integer sva_fails;
		begin
			sva_fails = i_dut.i_ctrl.i_sva.fails;
			$display("errors: %0d wrong values, %0d timeouts, %0d assertion failures",
				value_errs, timeouts, sva_fails);
			if (value_errs + timeouts + sva_fails == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	endtask

	task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			value_errs = value_errs + 1;
		end
	endtask

	task automatic check_count(input string name, input integer exp, input integer act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
			value_errs = value_errs + 1;
		end
	endtask

	// read model: one AR, then arlen+1 beats with random gaps
	initial begin : read_model
		integer d;
		integer i;
		logic [31:0] ra;
		logic [7:0]  rl;
		forever begin
			@(negedge clk);
			if (arvalid === 1'b1 && !rst) begin
				d = pick_delay();
				repeat (d) @(negedge clk);
				@(posedge clk);
				#2;
				arready = 1'b1;
				// arvalid still high here, so the handshake lands on the next edge
				@(negedge clk);
				ra = araddr;
				rl = arlen;
				ar_count = ar_count + 1;
				last_araddr = ra;
				last_arlen = rl;
				@(posedge clk);
				#2;
				arready = 1'b0;
				for (i = 0; i <= rl; i++) begin
					d = pick_delay();
					rvalid = 1'b0;
					repeat (d) begin
						@(posedge clk);
						#2;
					end
					rvalid = 1'b1;
					rlast = (i == rl);
					rdata = mem_word(ra + 8 * i);
					// R is always taken at the next edge
					@(posedge clk);
					#2;
				end
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	end

	// write model: AW, then W, then a single B pulse
	initial begin : write_model
		integer d;
		integer k;
		logic [31:0] wa;
		logic [63:0] wd;
		logic [7:0]  ws;
		forever begin
			@(negedge clk);
			if (awvalid === 1'b1 && !rst) begin
				d = pick_delay();
				repeat (d) @(negedge clk);
				@(posedge clk);
				#2;
				awready = 1'b1;
				@(negedge clk);
				wa = awaddr;
				@(posedge clk);
				#2;
				awready = 1'b0;
				k = 0;
				@(negedge clk);
				while (wvalid !== 1'b1 && k < WAIT_LIMIT) begin
					@(negedge clk);
					k = k + 1;
				end
				if (wvalid !== 1'b1) begin
					$display("timeout: write data never followed the write address");
					timeouts = timeouts + 1;
					final_report();
				end else begin
					d = pick_delay();
					repeat (d) @(negedge clk);
					@(posedge clk);
					#2;
					wready = 1'b1;
					@(negedge clk);
					wd = wdata;
					ws = wstrb;
					@(posedge clk);
					#2;
					wready = 1'b0;
					mem_words[{wa[31:3], 3'b000}] = merge_bytes(mem_word(wa), wd, ws);
					d = pick_delay();
					repeat (d) begin
						@(posedge clk);
						#2;
					end
					bvalid = 1'b1;
					@(posedge clk);
					#2;
					bvalid = 1'b0;
				end
			end
		end
	end

	// one CPU request, held until ready, then dropped
	task automatic cpu_access(input logic [31:0] a, input logic we, input logic [63:0] d,
			input logic [7:0] m, output logic [63:0] q);
		integer n;
		begin
			n = 0;
			@(posedge clk);
			#2;
			valid = 1'b1;
			addr = a;
			wren = we;
			din = d;
			mask = m;
			@(negedge clk);
			while (ready !== 1'b1 && n < WAIT_LIMIT) begin
				@(negedge clk);
				n = n + 1;
			end
			if (ready !== 1'b1) begin
				$display("timeout: no ready for the %s at %h", we ? "write" : "read", a);
				timeouts = timeouts + 1;
				final_report();
			end else begin
				q = dout;
				@(posedge clk);
				#2;
				valid = 1'b0;
				wren = 1'b0;
			end
		end
	endtask

	task automatic cpu_read(input logic [31:0] a, output logic [63:0] q);
		cpu_access(a, 1'b0, '0, '0, q);
	endtask

	task automatic cpu_write(input logic [31:0] a, input logic [63:0] d, input logic [7:0] m);
		logic [63:0] unused;
		cpu_access(a, 1'b1, d, m, unused);
	endtask

	task automatic test_read_miss_hit;
		logic [31:0] a;
		logic [63:0] q;
		integer n0;
		begin
			a = 32'h0000_1058;
			n0 = ar_count;
			cpu_read(a, q);
			check_count("ar_count", n0 + 1, ar_count);
			check_word("araddr", {32'h0, a & ~32'h3f}, {32'h0, last_araddr});
			check_count("arlen", 7, last_arlen);
			check_word("dout", mem_word(a), q);
			// every word of the line now hits
			for (int i = 0; i < 8; i++) begin
				cpu_read((a & ~32'h3f) + 8 * i, q);
				check_word("dout", mem_word((a & ~32'h3f) + 8 * i), q);
			end
			check_count("ar_count", n0 + 1, ar_count);
		end
	endtask

	task automatic test_write_hit;
		logic [31:0] a;
		logic [63:0] d;
		logic [63:0] q;
		logic [63:0] exp;
		logic [7:0]  m;
		integer n0;
		begin
			a = 32'h0000_1060;
			d = {$random(stim_seed), $random(stim_seed)};
			m = $random(stim_seed);
			exp = merge_bytes(mem_word(a), d, m);
			n0 = ar_count;
			cpu_write(a, d, m);
			check_word("memory", exp, mem_word(a));
			cpu_read(a, q);
			check_word("dout", exp, q);
			check_count("ar_count", n0, ar_count);
		end
	endtask

	task automatic test_write_miss;
		logic [31:0] a;
		logic [63:0] d;
		logic [63:0] q;
		logic [63:0] exp;
		integer n0;
		begin
			a = 32'h0000_2090;
			d = 64'h0123_4567_89ab_cdef;
			exp = merge_bytes(mem_word(a), d, 8'h3c);
			n0 = ar_count;
			cpu_write(a, d, 8'h3c);
			check_word("memory", exp, mem_word(a));
			// no allocate, so the write leaves no AR behind
			check_count("ar_count", n0, ar_count);
			cpu_read(a, q);
			check_count("ar_count", n0 + 1, ar_count);
			check_word("dout", exp, q);
		end
	endtask

	task automatic test_replacement;
		logic [31:0] a [5];
		logic [63:0] q;
		integer n0;
		begin
			// five tags, all in set 5
			for (int k = 0; k < 5; k++) begin
				a[k] = 32'h0000_4148 + k * 32'h400;
			end
			n0 = ar_count;
			for (int k = 0; k < 5; k++) begin
				cpu_read(a[k], q);
				check_word("dout", mem_word(a[k]), q);
			end
			check_count("ar_count", n0 + 5, ar_count);
			// lines two to five survive, the first was evicted by the fifth
			n0 = ar_count;
			for (int k = 1; k < 5; k++) begin
				cpu_read(a[k], q);
				check_word("dout", mem_word(a[k]), q);
			end
			check_count("ar_count", n0, ar_count);
			cpu_read(a[0], q);
			check_word("dout", mem_word(a[0]), q);
			check_count("ar_count", n0 + 1, ar_count);
		end
	endtask

	task automatic test_device;
		logic [31:0] a;
		logic [63:0] q;
		logic [63:0] d;
		logic [63:0] exp;
		integer n0;
		begin
			a = `DC_DEVICE_BASE + 32'h20;
			// never cached, each read goes out as one beat
			for (int i = 0; i < 2; i++) begin
				n0 = ar_count;
				cpu_read(a, q);
				check_count("ar_count", n0 + 1, ar_count);
				check_count("arlen", 0, last_arlen);
				check_word("araddr", {32'h0, a}, {32'h0, last_araddr});
				check_word("dout", mem_word(a), q);
			end
			d = 64'hfeed_face_cafe_beef;
			exp = merge_bytes(mem_word(a), d, 8'hf0);
			cpu_write(a, d, 8'hf0);
			check_word("memory", exp, mem_word(a));
			n0 = ar_count;
			cpu_read(a, q);
			check_count("ar_count", n0 + 1, ar_count);
			check_word("dout", exp, q);
		end
	endtask

	task automatic test_random;
		logic [31:0] a;
		logic [63:0] d;
		logic [63:0] q;
		logic [7:0]  m;
		begin
			// 64 words over eight lines, untouched by the earlier tests
			for (int k = 0; k < 40; k++) begin
				a = 32'h0000_8000 + (($random(stim_seed) & 32'h3f) << 3);
				if ($random(stim_seed) & 1) begin
					d = {$random(stim_seed), $random(stim_seed)};
					m = $random(stim_seed);
					cpu_write(a, d, m);
					shadow[a] = merge_bytes(shadow_word(a), d, m);
				end else begin
					cpu_read(a, q);
					check_word("dout", shadow_word(a), q);
				end
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		wren = 1'b0;
		din = '0;
		mask = '0;
		arready = 1'b0;
		rdata = '0;
		rlast = 1'b0;
		rvalid = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		test_read_miss_hit();
		test_write_hit();
		test_write_miss();
		test_replacement();
		test_device();
		test_random();
		final_report();
	end

endmodule

`default_nettype wire

//--- dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tags.sv
verilog/dcache_data.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
tb/dcache_sva.sv
tb/dcache_tb.sv
